// ==== dsp.f ====
+incdir+rtl
rtl/dsp_pkg.sv
rtl/shot_sequencer.sv
rtl/proc_core.sv
rtl/gate_acc.sv
rtl/capture_writer.sv
rtl/dsp.sv
tb/tb_clkgen.sv
tb/dsp_asserts.sv
tb/dsp_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dsp_tb -f dsp.f -o dsp_sim \
	&& ./obj_dir/dsp_sim > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// ==== tb/dsp_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module dsp_tb import dsp_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int SHOT_CYCLES = 80;
	localparam int ACQ_CYCLES = 40;
	// reset, at most 31 shots over seven runs with setup and drain, two capture passes.
	localparam int TEST_CYCLES = 16 + 31 * SHOT_CYCLES + 7 * 16 + 2 * (ACQ_CYCLES + 1) + 100;

	logic dspif;
	logic rst_n;
	adc_pair_t adc;
	logic stb_start;
	logic [31:0] nshot;
	logic resetacc;
	logic stb_reset_bram_read;
	cmd_t cmd_data [`DSP_NPROC];
	cmd_addr_t cmd_addr [`DSP_NPROC];
	logic lastshotdone;
	logic [31:0] shotcnt;
	accbuf_wr_t accbuf [`DSP_NPROC];
	acqbuf_wr_t acqbuf;

	cmd_t cmd_mem [`DSP_NPROC][16];
	cmd_addr_t addr_prev [`DSP_NPROC] = '{default: '0};
	int ncmd [`DSP_NPROC];
	int widx [`DSP_NPROC];
	int nwrites [`DSP_NPROC];
	acc_addr_t acc_addr_exp [`DSP_NPROC] = '{default: '0};
	adc_pair_t adc_hist [3];
	acq_addr_t acq_addr_exp = '0;
	int acq_writes = 0;
	int done_cnt = 0;
	logic [31:0] done_shotcnt = '0;
	string test_name = "reset";
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	tb_clkgen clkgen_i (.*);
	dsp dut_i (.*);

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// inputs change a little after the rising edge.
	task automatic next_cycle();
		@(posedge dspif);
		#5;
	endtask

	task automatic report_test(input string name, input int start_err);
		if (errors == start_err) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start_err);
		end
	endtask

	// windows never overlap and leave at least one idle count for the next fetch.
	task automatic make_tables();
		int t;
		for (int c = 0; c < `DSP_NPROC; c++) begin
			ncmd[c] = 1 + $urandom_range(3);
			t = 2 + $urandom_range(3);
			for (int i = 0; i < 16; i++) begin
				cmd_mem[c][i] = '0;
			end
			for (int i = 0; i < ncmd[c]; i++) begin
				cmd_mem[c][i].start = 15'(t);
				cmd_mem[c][i].len = 16'(1 + $urandom_range(7));
				cmd_mem[c][i].last = (i == ncmd[c] - 1);
				t = t + int'(cmd_mem[c][i].len) + 2 + $urandom_range(3);
			end
		end
	endtask

	// the sample is held for the whole run, so each sum is the window length times it.
	task automatic record_acc_write(input int c);
		int len;
		acc_t ex;
		acc_t ey;
		len = int'(cmd_mem[c][widx[c]].len);
		ex = len * int'(adc.x);
		ey = len * int'(adc.y);
		check({test_name, " acc sum"}, {ex, ey}, accbuf[c].data);
		check({test_name, " acc addr"}, acc_addr_exp[c], accbuf[c].addr);
		if (acc_addr_exp[c] != '1) begin
			acc_addr_exp[c]++;
		end
		widx[c] = (widx[c] + 1) % ncmd[c];
		nwrites[c]++;
	endtask

	task automatic run_shots(input string name, input int n, input logic clear_acc);
		int start_err;
		int shots;
		int waited;
		start_err = errors;
		test_name = name;
		shots = (n == 0) ? 1 : n;
		make_tables();
		adc = $urandom;
		nshot = n;
		done_cnt = 0;
		resetacc = clear_acc;
		for (int c = 0; c < `DSP_NPROC; c++) begin
			widx[c] = 0;
			nwrites[c] = 0;
			if (clear_acc) begin
				acc_addr_exp[c] = '0;
			end
		end
		next_cycle();
		resetacc = 1'b0;
		repeat (3) next_cycle();
		stb_start = 1'b1;
		next_cycle();
		stb_start = 1'b0;
		waited = 0;
		while (done_cnt == 0 && waited < shots * SHOT_CYCLES) begin
			next_cycle();
			waited++;
		end
		if (done_cnt == 0) begin
			$display("%s: no lastshotdone after %0d cycles", name, waited);
			errors++;
		end
		repeat (8) next_cycle();
		check({name, " pulses"}, 1, done_cnt);
		check({name, " shotcnt"}, (shots < 2) ? 0 : shots - 2, done_shotcnt);
		for (int c = 0; c < `DSP_NPROC; c++) begin
			check({name, " writes"}, shots * ncmd[c], nwrites[c]);
		end
		report_test(name, start_err);
	endtask

	task automatic run_acq(input string name);
		int start_err;
		start_err = errors;
		test_name = name;
		// the second pass restarts from the parked address.
		repeat (2) begin
			acq_writes = 0;
			acq_addr_exp = '0;
			stb_reset_bram_read = 1'b1;
			adc = $urandom;
			next_cycle();
			stb_reset_bram_read = 1'b0;
			repeat (ACQ_CYCLES) begin
				adc = $urandom;
				next_cycle();
			end
			check({name, " acq writes"}, (1 << `DSP_ACQ_AW) - 1, acq_writes);
			check({name, " acq parked"}, 0, acqbuf.we);
		end
		report_test(name, start_err);
	endtask

	// command memory with one cycle of read latency.
	always @(posedge dspif) begin
		#5;
		for (int c = 0; c < `DSP_NPROC; c++) begin
			cmd_data[c] = cmd_mem[c][addr_prev[c]];
			addr_prev[c] = cmd_addr[c];
		end
	end

	always @(negedge dspif) begin
		if (lastshotdone === 1'b1) begin
			done_cnt++;
			done_shotcnt = shotcnt;
		end
		for (int c = 0; c < `DSP_NPROC; c++) begin
			if (accbuf[c].we === 1'b1) begin
				record_acc_write(c);
			end
		end
		// a capture write carries the input driven three cycles earlier.
		if (acqbuf.we === 1'b1) begin
			check({test_name, " acq data"}, adc_hist[2], acqbuf.data);
			check({test_name, " acq addr"}, acq_addr_exp, acqbuf.addr);
			acq_addr_exp++;
			acq_writes++;
		end
		adc_hist[2] = adc_hist[1];
		adc_hist[1] = adc_hist[0];
		adc_hist[0] = adc;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD);
		$display("watchdog: the tests did not finish within %0d cycles", TEST_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(32'h688e));
		adc = '0;
		stb_start = 1'b0;
		nshot = '0;
		resetacc = 1'b0;
		stb_reset_bram_read = 1'b0;
		for (int c = 0; c < `DSP_NPROC; c++) begin
			cmd_data[c] = '0;
		end
		wait (rst_n === 1'b1);
		next_cycle();
		run_shots("shot_run_zero", 0, 1'b0);
		for (int i = 1; i <= 4; i++) begin
			run_shots($sformatf("shot_run_%0d", i), $urandom_range(5), 1'b0);
		end
		run_shots("acc_addr_hold", 9, 1'b1);
		run_shots("acc_addr_restart", 1, 1'b1);
		run_acq("acq_capture");
		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/dsp_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module dsp_asserts import dsp_pkg::*; (
	input wire dspif,
	input wire rst_n,
	input wire lastshotdone,
	input wire stb_reset_bram_read,
	input wire accbuf_wr_t accbuf [`DSP_NPROC],
	input wire acqbuf_wr_t acqbuf
);

	// the end of a run is marked by a single-cycle strobe.
	done_single: assert property (@(posedge dspif) disable iff (!rst_n)
		lastshotdone |=> !lastshotdone)
		else $error("lastshotdone stayed high for two cycles");

	for (genvar i = 0; i < `DSP_NPROC; i++) begin : g_acc
		acc_we_single: assert property (@(posedge dspif) disable iff (!rst_n)
			accbuf[i].we |=> !accbuf[i].we)
			else $error("accumulation write of core %0d lasted more than one cycle", i);
	end

	// capture stays on the last address, with writes off, until a read-reset strobe.
	acq_we_parked: assert property (@(posedge dspif) disable iff (!rst_n)
		(&acqbuf.addr) && !$past(stb_reset_bram_read) |=> (&acqbuf.addr) && !acqbuf.we)
		else $error("acquisition capture left the last address without a read-reset strobe");

endmodule

bind dsp dsp_asserts asserts_i (
	.dspif(dspif),
	.rst_n(rst_n),
	.lastshotdone(lastshotdone),
	.stb_reset_bram_read(stb_reset_bram_read),
	.accbuf(accbuf),
	.acqbuf(acqbuf)
);

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic dspif,
	output logic rst_n
);

	initial begin
		dspif = 1'b0;
		forever #(PERIOD / 2) dspif = ~dspif;
	end

	// reset is released just after an edge, like every other input.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge dspif);
		#5;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== rtl/dsp.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module dsp import dsp_pkg::*; (
	input wire dspif,
	input wire rst_n,
	input wire adc_pair_t adc,
	input wire stb_start,
	input wire [31:0] nshot,
	input wire resetacc,
	input wire stb_reset_bram_read,
	input wire cmd_t cmd_data [`DSP_NPROC],
	output cmd_addr_t cmd_addr [`DSP_NPROC],
	output logic lastshotdone,
	output logic [31:0] shotcnt,
	output accbuf_wr_t accbuf [`DSP_NPROC],
	output acqbuf_wr_t acqbuf
);

	adc_pair_t adc_q;
	logic resetacc_q;
	logic [`DSP_NPROC-1:0] core_reset;
	logic [`DSP_NPROC-1:0] procdone;
	logic [`DSP_NPROC-1:0] gate;

	always_ff @(posedge dspif) begin
		adc_q <= adc;
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			resetacc_q <= 1'b0;
		end else begin
			resetacc_q <= resetacc;
		end
	end

	shot_sequencer seq_i (
		.dspif(dspif),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.procdone(procdone),
		.core_reset(core_reset),
		.lastshotdone(lastshotdone),
		.shotcnt(shotcnt)
	);

	// each core drives the gate of its own accumulator.
	for (genvar i = 0; i < `DSP_NPROC; i++) begin : g_proc
		proc_core core_i (
			.dspif(dspif),
			.core_reset(core_reset[i]),
			.cmd_data(cmd_data[i]),
			.cmd_addr(cmd_addr[i]),
			.gate(gate[i]),
			.procdone(procdone[i])
		);

		gate_acc acc_i (
			.dspif(dspif),
			.rst_n(rst_n),
			.adc_q(adc_q),
			.gate(gate[i]),
			.resetacc(resetacc_q),
			.accbuf(accbuf[i])
		);
	end

	capture_writer cap_i (
		.dspif(dspif),
		.rst_n(rst_n),
		.adc_q(adc_q),
		.stb_reset_bram_read(stb_reset_bram_read),
		.acqbuf(acqbuf)
	);

endmodule

`default_nettype wire

// ==== rtl/capture_writer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module capture_writer import dsp_pkg::*; (
	input wire dspif,
	input wire rst_n,
	input wire adc_pair_t adc_q,
	input wire stb_reset_bram_read,
	output acqbuf_wr_t acqbuf
);

	// adc_q and the output register account for two of the delay cycles.
	localparam int LINE = `DSP_ACQ_DELAY - 2;

	adc_pair_t dly [LINE];
	adc_pair_t data;
	logic stb_q;
	acq_addr_t addr;
	logic we;

	assign we = !(&addr);

	// capture stays parked on the last address until the first read-reset strobe.
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			stb_q <= 1'b0;
			addr <= '1;
		end else begin
			stb_q <= stb_reset_bram_read;
			if (stb_q) begin
				addr <= '0;
			end else if (we) begin
				addr <= addr + 1'b1;
			end
		end
	end

	always_ff @(posedge dspif) begin
		dly[0] <= adc_q;
		for (int i = 1; i < LINE; i++) begin
			dly[i] <= dly[i-1];
		end
		data <= dly[LINE-1];
	end

	assign acqbuf = {we, addr, data};

endmodule

`default_nettype wire

// ==== rtl/gate_acc.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module gate_acc import dsp_pkg::*; (
	input wire dspif,
	input wire rst_n,
	input wire adc_pair_t adc_q,
	input wire gate,
	input wire resetacc,
	output accbuf_wr_t accbuf
);

	acc_t sum_x;
	acc_t sum_y;
	acc_t data_x;
	acc_t data_y;
	logic gate_d;
	logic gate_fall;
	logic we;
	acc_addr_t addr;

	assign gate_fall = gate_d && !gate;

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			gate_d <= 1'b0;
			we <= 1'b0;
			addr <= '0;
			sum_x <= '0;
			sum_y <= '0;
		end else begin
			gate_d <= gate;
			we <= gate_fall;
			// the running sum is handed off and restarted once the window is over.
			if (gate_fall) begin
				sum_x <= '0;
				sum_y <= '0;
			end else if (gate) begin
				sum_x <= sum_x + acc_t'(adc_q.x);
				sum_y <= sum_y + acc_t'(adc_q.y);
			end
			// address locks on the last entry until the host clears it.
			if (resetacc) begin
				addr <= '0;
			end else if (we && !(&addr)) begin
				addr <= addr + 1'b1;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (gate_fall) begin
			data_x <= sum_x;
			data_y <= sum_y;
		end
	end

	assign accbuf = {we, addr, data_x, data_y};

endmodule

`default_nettype wire

// ==== rtl/proc_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module proc_core import dsp_pkg::*; (
	input wire dspif,
	input wire core_reset,
	input wire cmd_t cmd_data,
	output cmd_addr_t cmd_addr,
	output logic gate,
	output logic procdone
);

	// shot timer, counting from zero once the core leaves reset.
	tcnt_t tcnt;

	// cmd_data matches cmd_addr only one cycle after the address moves.
	logic cmd_valid;

	// window bounds carry one extra bit so start plus len never wraps.
	logic [16:0] tcnt_ext;
	logic [16:0] win_start;
	logic [16:0] win_stop;
	logic in_window;
	logic closing;

	assign tcnt_ext = {1'b0, tcnt};
	assign win_start = {2'b00, cmd_data.start};
	assign win_stop = win_start + {1'b0, cmd_data.len};
	assign in_window = (tcnt_ext >= win_start) && (tcnt_ext < win_stop);

	assign gate = cmd_valid && in_window;

	// the window ends after this cycle.
	// a window already behind the timer is dropped instead of stalling the core.
	assign closing = cmd_valid && (tcnt_ext + 17'd1 >= win_stop);

	// after a close the next command is valid two counts later,
	// so a following window should start at least one count after this one ends.
	always_ff @(posedge dspif) begin
		if (core_reset) begin
			tcnt <= '0;
			cmd_addr <= '0;
			cmd_valid <= 1'b0;
			procdone <= 1'b0;
		end else begin
			tcnt <= tcnt + 16'd1;
			if (closing) begin
				cmd_valid <= 1'b0;
				if (cmd_data.last) begin
					procdone <= 1'b1;
				end else begin
					cmd_addr <= cmd_addr + 1'b1;
				end
			end else if (!cmd_valid && !procdone) begin
				cmd_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/shot_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "dsp_params.svh"

module shot_sequencer import dsp_pkg::*; (
	input wire dspif,
	input wire rst_n,
	input wire stb_start,
	input wire [31:0] nshot,
	input wire [`DSP_NPROC-1:0] procdone,
	output logic [`DSP_NPROC-1:0] core_reset,
	output logic lastshotdone,
	output logic [31:0] shotcnt
);

	seq_state_t state;
	seq_state_t next_state;
	logic [31:0] nshot_q;
	logic [31:0] shot_num;
	logic [31:0] next_shot;

	assign next_shot = shot_num + 32'd1;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (stb_start) begin
					next_state = START;
				end
			end
			START: begin
				next_state = PROCRUN;
			end
			PROCRUN: begin
				if (&procdone) begin
					next_state = MORESHOT;
				end
			end
			MORESHOT: begin
				// a count of zero still runs a single shot.
				if (nshot_q == 32'd0 || next_shot == nshot_q) begin
					next_state = DONE;
				end else begin
					next_state = SHOTADD;
				end
			end
			SHOTADD: begin
				next_state = START;
			end
			DONE: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// outputs are registered from the next state so they line up with the state itself.
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= IDLE;
			core_reset <= '1;
			lastshotdone <= 1'b0;
			shot_num <= '0;
			shotcnt <= '0;
			nshot_q <= '0;
		end else begin
			state <= next_state;
			core_reset <= {`DSP_NPROC{!(next_state == START || next_state == PROCRUN)}};
			lastshotdone <= (next_state == DONE);
			if (state == IDLE || state == START) begin
				nshot_q <= nshot;
			end
			if (state == IDLE && next_state == START) begin
				shotcnt <= '0;
			end else if (next_state == SHOTADD) begin
				shotcnt <= shot_num;
				shot_num <= next_shot;
			end else if (next_state == DONE) begin
				shot_num <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dsp_pkg.sv ====
`default_nettype none
`include "dsp_params.svh"

package dsp_pkg;

	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t x;
		sample_t y;
	} adc_pair_t;

	typedef logic [15:0] tcnt_t;

	typedef logic [`DSP_CMD_AW-1:0] cmd_addr_t;
	typedef logic [`DSP_ACC_AW-1:0] acc_addr_t;
	typedef logic [`DSP_ACQ_AW-1:0] acq_addr_t;

	// one gate window. start is compared against the shot timer.
	typedef struct packed {
		logic last;
		logic [14:0] start;
		logic [15:0] len;
	} cmd_t;

	typedef logic signed [31:0] acc_t;

	typedef struct packed {
		logic we;
		acc_addr_t addr;
		struct packed {
			acc_t x;
			acc_t y;
		} data;
	} accbuf_wr_t;

	typedef struct packed {
		logic we;
		acq_addr_t addr;
		adc_pair_t data;
	} acqbuf_wr_t;

	typedef enum logic [2:0] {IDLE, START, PROCRUN, MORESHOT, SHOTADD, DONE} seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/dsp_params.svh ====
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// number of processor cores, and of gate accumulators.
`define DSP_NPROC 2

// command memory address width per core.
`define DSP_CMD_AW 4

// accumulation buffer address width, 8 entries per core.
`define DSP_ACC_AW 3

// acquisition buffer address width.
`define DSP_ACQ_AW 5

// cycles from the top-level adc input to the acquisition buffer write.
// the input register counts as one of them, so this must be at least 3.
`define DSP_ACQ_DELAY 3

`endif
